// ==== mips_cpu.f ====
+incdir+include
logic/mips_pkg.sv
logic/mips_alu.sv
logic/mips_control.sv
logic/mips_pc.sv
logic/mips_regfile.sv
logic/mips_execute.sv
logic/mips_cpu.sv
test/mips_tb_clock.sv
test/mips_tb.sv

// ==== Makefile ====
TOP = mips_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f mips_cpu.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/mips_tb.sv ====
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_tb import mips_pkg::*; ();

  logic                    clk;
  logic                    rst_n;
  logic                    rst_req;
  logic [`MIPS_DATA_W-1:0] instr;
  logic [`MIPS_DATA_W-1:0] dmem_rdata;
  logic [`MIPS_DATA_W-1:0] instr_addr;
  logic [`MIPS_DATA_W-1:0] dmem_addr;
  logic [`MIPS_DATA_W-1:0] dmem_wdata;
  logic                    dmem_we;

  // memories played by the testbench
  logic [31:0] imem [256];
  logic [31:0] dmem [64];
  // instruction-set model state
  logic [31:0] mdl_reg [32];
  logic [31:0] mdl_mem [64];
  // recorded traces
  logic [31:0] exp_pc [$];
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];

  int     prog_len;
  int     errors;
  int     failed_tests;
  longint deadline = 0;
  string  test_names [6] = '{"reset", "alu", "mem", "branch", "jump", "random"};

  mips_tb_clock i_clock (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  mips_cpu i_mips_cpu (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (instr),
    .dmem_rdata (dmem_rdata),
    .instr_addr (instr_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we)
  );

  // both memories answer combinationally
  assign instr      = imem[instr_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  function automatic int rnd(int n);
    return $urandom_range(n - 1, 0);
  endfunction

  // start value of a data word from its full index
  function automatic logic [31:0] fill_word(int i);
    return 32'h3c5a_0000 ^ (32'(i) * 32'h0001_0205);
  endfunction

  function automatic logic [31:0] enc_r(logic [5:0] fn, int rd, int rs, int rt);
    return {op_r_type, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(logic [5:0] op, int rt, int rs, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [31:0] enc_j(logic [5:0] op, int word);
    return {op, 26'(word)};
  endfunction

  // random word offset around the base in r28 within 64 words
  function automatic logic [15:0] rand_off();
    return 16'((rnd(64) - 32) * 4);
  endfunction

  function automatic logic [31:0] rand_alu(int rd);
    int         rs;
    int         rt;
    logic [15:0] imm;
    rs  = rnd(16);
    rt  = rnd(16);
    imm = 16'($urandom);
    case (rnd(7))
      0:       return enc_r(fn_add, rd, rs, rt);
      1:       return enc_r(fn_sub, rd, rs, rt);
      2:       return enc_r(fn_and, rd, rs, rt);
      3:       return enc_r(fn_or, rd, rs, rt);
      4:       return enc_r(fn_slt, rd, rs, rt);
      5:       return enc_i(op_addi, rd, rs, imm);
      default: return enc_i(op_ori, rd, rs, imm);
    endcase
  endfunction

  task automatic emit(logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // base register then r1..r8 with mixed-sign values
  task automatic prologue();
    emit(enc_i(op_ori, 28, 0, 16'd128));
    for (int r = 1; r <= 8; r++) begin
      emit(enc_i(op_ori, r, 0, 16'($urandom)));
      emit(enc_i(op_addi, r, r, 16'($urandom)));
    end
  endtask

  task automatic build(int t);
    int         a;
    int         b;
    int         k;
    int         remain;
    int         end_idx;
    logic [15:0] off;
    logic [5:0]  op;
    prog_len = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    case (t)
      0: begin
        // store sits at address 0 while reset is held
        emit(enc_i(op_sw, 0, 0, 16'd4));
      end
      1: begin
        prologue();
        repeat (20) begin
          a = rnd(16);
          emit(rand_alu(a));
          emit(enc_i(op_sw, a, 28, rand_off()));
        end
      end
      2: begin
        prologue();
        repeat (12) begin
          a   = rnd(9);
          b   = 1 + rnd(8);
          off = rand_off();
          emit(enc_i(op_sw, a, 28, off));
          // reload the same word or another one
          emit(enc_i(op_lw, b, 28, (rnd(2) == 1) ? off : rand_off()));
          emit(enc_i(op_sw, b, 28, rand_off()));
        end
      end
      3: begin
        prologue();
        repeat (12) begin
          a  = rnd(9);
          b  = (rnd(2) == 1) ? a : rnd(9);
          op = (rnd(2) == 1) ? op_beq : op_bne;
          emit(enc_i(op, b, a, 16'(rnd(4))));
          repeat (3) emit(rand_alu(1 + rnd(15)));
        end
      end
      4: begin
        prologue();
        repeat (8) begin
          k = rnd(4);
          emit(enc_j((rnd(2) == 1) ? op_j : op_jal, prog_len + 1 + k));
          repeat (k) emit(rand_alu(1 + rnd(15)));
          emit(enc_i(op_sw, `MIPS_LINK_REG, 28, rand_off()));
        end
      end
      default: begin
        prologue();
        end_idx = prog_len + 200;
        repeat (200) begin
          // slots left before the halt
          remain = end_idx - prog_len - 1;
          k      = rnd(4);
          if (k > remain) begin
            k = remain;
          end
          case (rnd(10))
            4: emit(enc_i(op_lw, rnd(16), 28, rand_off()));
            5: emit(enc_i(op_sw, rnd(16), 28, rand_off()));
            6: emit(enc_i((rnd(2) == 1) ? op_beq : op_bne, rnd(9), rnd(9), 16'(k)));
            7: emit(enc_j((rnd(2) == 1) ? op_j : op_jal, prog_len + 1 + k));
            8: begin
              op = 6'($urandom);
              if (op inside {op_r_type, op_j, op_jal, op_beq, op_bne,
                             op_addi, op_ori, op_lw, op_sw}) begin
                op = 6'h3f;
              end
              emit({op, 26'($urandom)});
            end
            9: begin
              // r-format with a function code outside the subset
              op = 6'($urandom);
              if (op inside {fn_add, fn_sub, fn_and, fn_or, fn_slt}) begin
                op = 6'h3f;
              end
              emit({op_r_type, 20'($urandom), op});
            end
            default: emit(rand_alu(rnd(16)));
          endcase
        end
      end
    endcase
    // self-jump ends the program
    emit(enc_j(op_j, prog_len));
  endtask

  task automatic mdl_write(logic [4:0] r, logic [31:0] v);
    // r0 stays zero
    if (r != 5'd0) begin
      mdl_reg[r] = v;
    end
  endtask

  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] nxt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] addr;
    int          steps;
    exp_pc.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    for (int i = 0; i < 32; i++) begin
      mdl_reg[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mdl_mem[i] = fill_word(i);
    end
    pc    = `MIPS_RESET_PC;
    steps = 0;
    while (steps < 1000) begin
      ins   = imem[pc[9:2]];
      exp_pc.push_back(pc);
      a     = mdl_reg[ins[25:21]];
      b     = mdl_reg[ins[20:16]];
      imm_s = {{16{ins[15]}}, ins[15:0]};
      addr  = a + imm_s;
      nxt   = pc + 32'd4;
      case (ins[31:26])
        op_r_type: begin
          case (ins[5:0])
            fn_add:  mdl_write(ins[15:11], a + b);
            fn_sub:  mdl_write(ins[15:11], a - b);
            fn_and:  mdl_write(ins[15:11], a & b);
            fn_or:   mdl_write(ins[15:11], a | b);
            fn_slt:  mdl_write(ins[15:11], {31'd0, $signed(a) < $signed(b)});
            default: ;
          endcase
        end
        op_addi: mdl_write(ins[20:16], addr);
        op_ori:  mdl_write(ins[20:16], a | {16'd0, ins[15:0]});
        op_lw:   mdl_write(ins[20:16], mdl_mem[addr[7:2]]);
        op_sw: begin
          mdl_mem[addr[7:2]] = b;
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
        end
        op_beq: begin
          if (a == b) begin
            nxt = pc + 32'd4 + (imm_s << 2);
          end
        end
        op_bne: begin
          if (a != b) begin
            nxt = pc + 32'd4 + (imm_s << 2);
          end
        end
        op_j: begin
          nxt = {nxt[31:28], ins[25:0], 2'b00};
        end
        op_jal: begin
          mdl_write(5'(`MIPS_LINK_REG), pc + 32'd4);
          nxt = {nxt[31:28], ins[25:0], 2'b00};
        end
        default: ;
      endcase
      // halt on self-jump
      if (nxt == pc) begin
        break;
      end
      pc = nxt;
      steps++;
    end
  endtask

  task automatic check(string tag, logic [31:0] exp_v, logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("MISMATCH %s expected %h actual %h", tag, exp_v, act_v);
      errors++;
    end
  endtask

  // step the DUT against the recorded traces at each negedge
  task automatic run_dut(string name);
    int          k;
    int          s;
    logic [5:0]  st_idx;
    logic [31:0] st_data;
    k = 0;
    s = 0;
    @(negedge clk);
    while (!rst_n) begin
      check({name, " reset fetch"}, `MIPS_RESET_PC, instr_addr);
      check({name, " reset store"}, 32'd0, 32'(dmem_we));
      @(negedge clk);
    end
    while (k < exp_pc.size()) begin
      check({name, " fetch"}, exp_pc[k], instr_addr);
      if (dmem_we) begin
        if (s < exp_st_addr.size()) begin
          check({name, " store addr"}, exp_st_addr[s], dmem_addr);
          check({name, " store data"}, exp_st_data[s], dmem_wdata);
        end else begin
          $display("test %s: store to %h that the model never made", name, dmem_addr);
          errors++;
        end
        s++;
        // memory takes the store just after the edge
        st_idx  = dmem_addr[7:2];
        st_data = dmem_wdata;
        @(posedge clk);
        #1;
        dmem[st_idx] = st_data;
      end
      k++;
      if (k < exp_pc.size()) begin
        @(negedge clk);
      end
    end
    if (s != exp_st_addr.size()) begin
      $display("test %s: saw %0d stores but the model made %0d", name, s,
               exp_st_addr.size());
      errors++;
    end
  endtask

  initial begin
    int err_before;
    rst_req      = 1'b0;
    errors       = 0;
    failed_tests = 0;
    prog_len     = 0;
    void'($urandom(32'hffd6_e8c7));
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
    end
    for (int t = 0; t < 6; t++) begin
      if (t > 0) begin
        @(posedge clk);
        #1 rst_req = 1'b1;
        wait (!rst_n);
        rst_req = 1'b0;
      end
      err_before = errors;
      build(t);
      deadline += 64'(prog_len + 20) * 8;
      for (int i = 0; i < 64; i++) begin
        dmem[i] = fill_word(i);
      end
      run_model();
      run_dut(test_names[t]);
      if (errors == err_before) begin
        $display("test %s: ok, %0d fetches, %0d stores", test_names[t], exp_pc.size(),
                 exp_st_addr.size());
      end else begin
        $display("test %s: %0d errors", test_names[t], errors - err_before);
        failed_tests++;
      end
    end
    $display("tests 6, failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // budget grows as each test is built
  initial begin
    @(negedge clk);
    while ($time <= deadline) begin
      @(negedge clk);
    end
    $display("timeout: run still going at %0t ns, budget was %0d ns", $time, deadline);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== test/mips_tb_clock.sv ====
`timescale 1ns/1ps

module mips_tb_clock (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset low for five cycles at start and again on each request
  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge rst_req);
      #1 rst_n = 1'b0;
    end
  end

endmodule

// ==== logic/mips_cpu.sv ====
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_cpu import mips_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`MIPS_DATA_W-1:0] instr,
  input  logic [`MIPS_DATA_W-1:0] dmem_rdata,
  output logic [`MIPS_DATA_W-1:0] instr_addr,
  output logic [`MIPS_DATA_W-1:0] dmem_addr,
  output logic [`MIPS_DATA_W-1:0] dmem_wdata,
  output logic                    dmem_we
);

  // instruction fields
  opcode_t     opcode;
  funct_t      funct;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [15:0] imm;
  logic [25:0] target;

  // decoder levels
  alu_op_t alu_op;
  wb_sel_t wb_sel;
  logic    alu_src_imm;
  logic    imm_zero_ext;
  logic    reg_dst_rd;
  logic    reg_we;
  logic    mem_we;
  logic    branch_eq;
  logic    branch_ne;
  logic    jump;

  // datapath
  logic [`MIPS_DATA_W-1:0] pc_plus4;
  logic [`MIPS_DATA_W-1:0] rd_data_a;
  logic [`MIPS_DATA_W-1:0] rd_data_b;
  logic [`MIPS_DATA_W-1:0] wr_data;
  logic [4:0]              wr_addr;
  logic                    zero;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign imm    = instr[15:0];
  assign target = instr[25:0];

  mips_control i_mips_control (
    .rst_n        (rst_n),
    .opcode       (opcode),
    .funct        (funct),
    .alu_op       (alu_op),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .reg_dst_rd   (reg_dst_rd),
    .reg_we       (reg_we),
    .wb_sel       (wb_sel),
    .mem_we       (mem_we),
    .branch_eq    (branch_eq),
    .branch_ne    (branch_ne),
    .jump         (jump)
  );

  // fetch address and next-pc selection
  mips_pc i_mips_pc (
    .clk        (clk),
    .rst_n      (rst_n),
    .imm        (imm),
    .target     (target),
    .zero       (zero),
    .branch_eq  (branch_eq),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .instr_addr (instr_addr),
    .pc_plus4   (pc_plus4)
  );

  mips_regfile i_mips_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rs),
    .rd_addr_b (rt),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .we        (reg_we),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  // operands, alu, write-back and data memory port
  mips_execute i_mips_execute (
    .instr        (instr),
    .rd_data_a    (rd_data_a),
    .rd_data_b    (rd_data_b),
    .pc_plus4     (pc_plus4),
    .alu_op       (alu_op),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .reg_dst_rd   (reg_dst_rd),
    .wb_sel       (wb_sel),
    .mem_we       (mem_we),
    .dmem_rdata   (dmem_rdata),
    .zero         (zero),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we)
  );

endmodule

// ==== logic/mips_execute.sv ====
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_execute import mips_pkg::*; (
  input  logic [`MIPS_DATA_W-1:0] instr,
  input  logic [`MIPS_DATA_W-1:0] rd_data_a,
  input  logic [`MIPS_DATA_W-1:0] rd_data_b,
  input  logic [`MIPS_DATA_W-1:0] pc_plus4,
  input  alu_op_t                 alu_op,
  input  logic                    alu_src_imm,
  input  logic                    imm_zero_ext,
  input  logic                    reg_dst_rd,
  input  wb_sel_t                 wb_sel,
  input  logic                    mem_we,
  input  logic [`MIPS_DATA_W-1:0] dmem_rdata,
  output logic                    zero,
  output logic [4:0]              wr_addr,
  output logic [`MIPS_DATA_W-1:0] wr_data,
  output logic [`MIPS_DATA_W-1:0] dmem_addr,
  output logic [`MIPS_DATA_W-1:0] dmem_wdata,
  output logic                    dmem_we
);

  // extended immediate and second operand
  logic [`MIPS_DATA_W-1:0] imm_ext;
  logic [`MIPS_DATA_W-1:0] alu_b;
  logic [`MIPS_DATA_W-1:0] alu_result;
  // fill bit for the upper half
  logic                    imm_fill;

  // ori pads with zeros, everything else copies the sign
  assign imm_fill = imm_zero_ext ? 1'b0 : instr[15];
  assign imm_ext  = {{(`MIPS_DATA_W-16){imm_fill}}, instr[15:0]};

  assign alu_b = alu_src_imm ? imm_ext : rd_data_b;

  mips_alu i_mips_alu (
    .op     (alu_op),
    .a      (rd_data_a),
    .b      (alu_b),
    .result (alu_result),
    .zero   (zero)
  );

  // destination is rd for r-format, rt for i-format, r31 for jal
  always_comb begin
    if (wb_sel == wb_link) begin
      wr_addr = 5'(`MIPS_LINK_REG);
    end else if (reg_dst_rd) begin
      wr_addr = instr[15:11];
    end else begin
      wr_addr = instr[20:16];
    end
  end

  // write-back source
  always_comb begin
    case (wb_sel)
      wb_mem:  wr_data = dmem_rdata;
      wb_link: wr_data = pc_plus4;
      default: wr_data = alu_result;
    endcase
  end

  // byte address from base plus offset, store data from rt
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rd_data_b;
  assign dmem_we    = mem_we;

endmodule

// ==== logic/mips_regfile.sv ====
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_regfile #(
  parameter int ADDR_W = $clog2(`MIPS_REG_COUNT)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [ADDR_W-1:0]       rd_addr_a,
  input  logic [ADDR_W-1:0]       rd_addr_b,
  input  logic [ADDR_W-1:0]       wr_addr,
  input  logic [`MIPS_DATA_W-1:0] wr_data,
  input  logic                    we,
  output logic [`MIPS_DATA_W-1:0] rd_data_a,
  output logic [`MIPS_DATA_W-1:0] rd_data_b
);

  // general purpose registers
  logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

  // single write port, r0 never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // asynchronous reads
  // a write lands at the edge that ends the instruction, so no bypass
  always_comb begin
    if (rd_addr_a == '0) begin
      rd_data_a = '0;
    end else begin
      rd_data_a = regs[rd_addr_a];
    end
  end

  always_comb begin
    if (rd_addr_b == '0) begin
      rd_data_b = '0;
    end else begin
      rd_data_b = regs[rd_addr_b];
    end
  end

endmodule

// ==== logic/mips_pc.sv ====
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_pc (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [15:0]             imm,
  input  logic [25:0]             target,
  input  logic                    zero,
  input  logic                    branch_eq,
  input  logic                    branch_ne,
  input  logic                    jump,
  output logic [`MIPS_DATA_W-1:0] instr_addr,
  output logic [`MIPS_DATA_W-1:0] pc_plus4
);

  // current fetch address
  logic [`MIPS_DATA_W-1:0] pc_q;
  // candidate next addresses
  logic [`MIPS_DATA_W-1:0] branch_off;
  logic [`MIPS_DATA_W-1:0] branch_addr;
  logic [`MIPS_DATA_W-1:0] jump_addr;
  logic [`MIPS_DATA_W-1:0] pc_next;
  logic                    branch_taken;

  assign pc_plus4 = pc_q + `MIPS_DATA_W'd4;

  // word offset, sign-extended then scaled to bytes
  assign branch_off  = {{(`MIPS_DATA_W-18){imm[15]}}, imm, 2'b00};
  assign branch_addr = pc_plus4 + branch_off;

  // region bits come from the incremented pc
  assign jump_addr = {pc_plus4[`MIPS_DATA_W-1:28], target, 2'b00};

  // beq wants equal operands, bne wants a difference
  assign branch_taken = (branch_eq & zero) | (branch_ne & ~zero);

  always_comb begin
    if (jump) begin
      pc_next = jump_addr;
    end else if (branch_taken) begin
      pc_next = branch_addr;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // one instruction per clock, never stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `MIPS_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign instr_addr = pc_q;

endmodule

// ==== logic/mips_control.sv ====
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
  input  logic    rst_n,
  input  opcode_t opcode,
  input  funct_t  funct,
  output alu_op_t alu_op,
  output logic    alu_src_imm,
  output logic    imm_zero_ext,
  output logic    reg_dst_rd,
  output logic    reg_we,
  output wb_sel_t wb_sel,
  output logic    mem_we,
  output logic    branch_eq,
  output logic    branch_ne,
  output logic    jump
);

  // decoded enables before the reset gate
  logic reg_we_dec;
  logic mem_we_dec;

  always_comb begin
    // defaults give a no-op
    alu_op       = alu_add;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    reg_dst_rd   = 1'b0;
    reg_we_dec   = 1'b0;
    wb_sel       = wb_alu;
    mem_we_dec   = 1'b0;
    branch_eq    = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    case (opcode)
      op_r_type: begin
        reg_dst_rd = 1'b1;
        // only known function codes write back
        case (funct)
          fn_add: begin
            alu_op     = alu_add;
            reg_we_dec = 1'b1;
          end
          fn_sub: begin
            alu_op     = alu_sub;
            reg_we_dec = 1'b1;
          end
          fn_and: begin
            alu_op     = alu_and;
            reg_we_dec = 1'b1;
          end
          fn_or: begin
            alu_op     = alu_or;
            reg_we_dec = 1'b1;
          end
          fn_slt: begin
            alu_op     = alu_slt;
            reg_we_dec = 1'b1;
          end
          default: begin
            reg_we_dec = 1'b0;
          end
        endcase
      end
      op_addi: begin
        alu_src_imm = 1'b1;
        reg_we_dec  = 1'b1;
      end
      op_ori: begin
        alu_op       = alu_or;
        alu_src_imm  = 1'b1;
        imm_zero_ext = 1'b1;
        reg_we_dec   = 1'b1;
      end
      op_lw: begin
        // address is base plus signed offset
        alu_src_imm = 1'b1;
        reg_we_dec  = 1'b1;
        wb_sel      = wb_mem;
      end
      op_sw: begin
        alu_src_imm = 1'b1;
        mem_we_dec  = 1'b1;
      end
      op_beq: begin
        // compare by subtraction, zero flag decides
        alu_op    = alu_sub;
        branch_eq = 1'b1;
      end
      op_bne: begin
        alu_op    = alu_sub;
        branch_ne = 1'b1;
      end
      op_j: begin
        jump = 1'b1;
      end
      op_jal: begin
        jump       = 1'b1;
        reg_we_dec = 1'b1;
        wb_sel     = wb_link;
      end
      default: begin
        jump = 1'b0;
      end
    endcase
  end

  // no architectural writes while held in reset
  assign reg_we = reg_we_dec & rst_n;
  assign mem_we = mem_we_dec & rst_n;

endmodule

// ==== logic/mips_alu.sv ====
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_alu import mips_pkg::*; (
  input  alu_op_t                 op,
  input  logic [`MIPS_DATA_W-1:0] a,
  input  logic [`MIPS_DATA_W-1:0] b,
  output logic [`MIPS_DATA_W-1:0] result,
  output logic                    zero
);

  // shared subtractor, also feeds slt
  logic [`MIPS_DATA_W-1:0] diff;
  logic                    less;

  assign diff = a - b;

  // signed compare without trusting the diff sign,
  // overflow would flip it
  always_comb begin
    if (a[`MIPS_DATA_W-1] != b[`MIPS_DATA_W-1]) begin
      // differing signs, the negative one is smaller
      less = a[`MIPS_DATA_W-1];
    end else begin
      less = diff[`MIPS_DATA_W-1];
    end
  end

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = diff;
      end
      alu_and: begin
        result = a & b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_slt: begin
        // one in the lsb, rest zero
        result = {{(`MIPS_DATA_W-1){1'b0}}, less};
      end
      default: begin
        result = a + b;
      end
    endcase
  end

  // used by beq and bne
  assign zero = (result == '0);

endmodule

// ==== logic/mips_pkg.sv ====
package mips_pkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op_r_type = 6'h00,
    op_j      = 6'h02,
    op_jal    = 6'h03,
    op_beq    = 6'h04,
    op_bne    = 6'h05,
    op_addi   = 6'h08,
    op_ori    = 6'h0d,
    op_lw     = 6'h23,
    op_sw     = 6'h2b
  } opcode_t;

  // function field of r-format, instr[5:0]
  typedef enum logic [5:0] {
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_t;

  // operation selected inside the alu
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  // source of the register write-back value
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_mem  = 2'd1,
    wb_link = 2'd2
  } wb_sel_t;

endpackage

// ==== include/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath word width in bits
`define MIPS_DATA_W 32

// architectural register count
`define MIPS_REG_COUNT 32

// first fetch address once reset is released
`define MIPS_RESET_PC 32'h0000_0000

// destination of the return address for jal
`define MIPS_LINK_REG 31

`endif
